/* rtl/mips_params.svh */
/*
 * Build-time constants for the single-cycle MIPS core and its memory models.
 * Include wherever memory sizing, the reset PC or the register count is needed.
 */

`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// data memory word address width, 128 words
`define MIPS_DMEM_AW 7

// first instruction fetched after reset
`define MIPS_RESET_PC 32'h0000_0000

// architectural register count
`define MIPS_NUM_REGS 32

`endif

/* rtl/mips_pkg.sv */
/*
 * Shared types and encodings for the MIPS subset core.
 * Opcode and funct codes are also used by the testbench to assemble programs.
 */

`include "mips_params.svh"

package mips_pkg;

    typedef logic [31:0]                 word_t;
    typedef logic [4:0]                  reg_addr_t;
    typedef logic [`MIPS_DMEM_AW-1:0]    dmem_addr_t;
    typedef logic [5:0]                  opcode_t;
    typedef logic [5:0]                  funct_t;
    typedef logic [3:0]                  alu_op_t;

    // ========================================
    // ALU operations
    // ========================================
    localparam alu_op_t ALU_AND = 4'b0000;
    localparam alu_op_t ALU_OR  = 4'b0001;
    localparam alu_op_t ALU_ADD = 4'b0010;
    localparam alu_op_t ALU_SUB = 4'b0110;
    localparam alu_op_t ALU_SLT = 4'b0111;

    // ========================================
    // instruction encodings
    // ========================================
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_JAL   = 6'h03;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // funct field of R-type
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

endpackage

/* rtl/mips_alu.sv */
/*
 * Integer ALU for the core: add, sub, and, or and signed set-less-than.
 * The zero flag drives the beq decision.
 */

module mips_alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  mips_pkg::alu_op_t op,
    output mips_pkg::word_t   result,
    output logic              zero
);

    import mips_pkg::*;

    logic lt_signed;

    assign lt_signed = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            // slt is signed
            ALU_SLT: result = {31'b0, lt_signed};
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* rtl/mips_decoder.sv */
/*
 * Main control and ALU control in one combinational block.
 * Unknown opcodes and unknown R-type functs decode as no-ops.
 */

module mips_decoder (
    input  mips_pkg::opcode_t opcode,
    input  mips_pkg::funct_t  funct,
    output logic              reg_dst,
    output logic              alu_src,
    output logic              mem_to_reg,
    output logic              reg_write,
    output logic              mem_read,
    output logic              mem_write,
    output logic              branch,
    output logic              jump,
    output logic              link,
    output mips_pkg::alu_op_t alu_op
);

    import mips_pkg::*;

    always_comb begin
        // no-op defaults
        reg_dst    = 1'b0;
        alu_src    = 1'b0;
        mem_to_reg = 1'b0;
        reg_write  = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        branch     = 1'b0;
        jump       = 1'b0;
        link       = 1'b0;
        alu_op     = ALU_ADD;

        case (opcode)
            OP_RTYPE: begin
                reg_dst   = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    FN_ADD:  alu_op = ALU_ADD;
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: reg_write = 1'b0;
                endcase
            end
            OP_LW: begin
                alu_src    = 1'b1;
                mem_to_reg = 1'b1;
                reg_write  = 1'b1;
                mem_read   = 1'b1;
            end
            OP_SW: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
            end
            // compare by subtraction, zero flag decides
            OP_BEQ: begin
                branch = 1'b1;
                alu_op = ALU_SUB;
            end
            OP_J: jump = 1'b1;
            OP_JAL: begin
                jump      = 1'b1;
                link      = 1'b1;
                reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    // the SRAM takes one access per cycle, read or write
    always_comb begin
        assert (!(mem_read && mem_write))
            else $error("decoder: read and write requested together");
    end

endmodule

/* rtl/mips_regfile.sv */
/*
 * General purpose register file, 32 x 32 bits.
 * Two combinational read ports and one write port at the rising edge.
 */

`include "mips_params.svh"

module mips_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we,
    input  mips_pkg::reg_addr_t raddr1,
    input  mips_pkg::reg_addr_t raddr2,
    input  mips_pkg::reg_addr_t waddr,
    input  mips_pkg::word_t     wdata,
    output mips_pkg::word_t     rdata1,
    output mips_pkg::word_t     rdata2
);

    import mips_pkg::*;

    word_t regs [`MIPS_NUM_REGS];

    // r0 is never written, so it keeps its reset value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // read in the same cycle as the instruction
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // holds across any earlier write aimed at r0
    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (raddr1 == '0) |-> (rdata1 == '0))
        else $error("regfile: r0 read back nonzero");

endmodule

/* rtl/mips_fetch.sv */
/*
 * Program counter and next-PC selection.
 * Branch takes priority over jump, otherwise fall through to PC+4.
 */

`include "mips_params.svh"

module mips_fetch (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            branch_taken,
    input  mips_pkg::word_t branch_offset,
    input  logic            jump,
    input  logic [25:0]     jump_target,
    output mips_pkg::word_t pc,
    output mips_pkg::word_t pc_plus4
);

    import mips_pkg::*;

    word_t pc_next;
    word_t branch_addr;
    word_t jump_addr;

    assign pc_plus4 = pc + 32'd4;

    // word offset relative to the delay-free PC+4
    assign branch_addr = pc_plus4 + {branch_offset[29:0], 2'b00};
    // region bits come from PC+4
    assign jump_addr   = {pc_plus4[31:28], jump_target, 2'b00};

    always_comb begin
        if (branch_taken) begin
            pc_next = branch_addr;
        end else if (jump) begin
            pc_next = jump_addr;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `MIPS_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("fetch: PC not word aligned");

endmodule

/* rtl/mips_core.sv */
/*
 * Single-cycle MIPS core top level, one instruction per clock.
 * Instruction ROM and data SRAM sit outside, reached through imem_addr/instr
 * and the active-low cen/wen strobes.
 */

`include "mips_params.svh"

module mips_core (
    input  logic                 clk,
    input  logic                 rst_n,
    output mips_pkg::word_t      imem_addr,
    input  mips_pkg::word_t      instr,
    output mips_pkg::dmem_addr_t dmem_addr,
    output mips_pkg::word_t      dmem_wdata,
    input  mips_pkg::word_t      dmem_rdata,
    output logic                 cen,
    output logic                 wen,
    output logic                 rf_we,
    output mips_pkg::word_t      rf_wdata
);

    import mips_pkg::*;

    word_t     pc;
    word_t     pc_plus4;
    word_t     imm_ext;
    word_t     rdata1;
    word_t     rdata2;
    word_t     alu_b;
    word_t     alu_result;
    reg_addr_t waddr;
    alu_op_t   alu_op;
    logic      reg_dst, alu_src, mem_to_reg, reg_write;
    logic      mem_read, mem_write, branch, jump, link;
    logic      zero;

    // ========================================
    // fetch and decode
    // ========================================
    mips_fetch fetch_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .branch_taken  (branch & zero),
        .branch_offset (imm_ext),
        .jump          (jump),
        .jump_target   (instr[25:0]),
        .pc            (pc),
        .pc_plus4      (pc_plus4)
    );

    mips_decoder decoder_i (
        .opcode     (instr[31:26]),
        .funct      (instr[5:0]),
        .reg_dst    (reg_dst),
        .alu_src    (alu_src),
        .mem_to_reg (mem_to_reg),
        .reg_write  (reg_write),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .branch     (branch),
        .jump       (jump),
        .link       (link),
        .alu_op     (alu_op)
    );

    assign imm_ext = {{16{instr[15]}}, instr[15:0]};

    // ========================================
    // register file and execute
    // ========================================
    // jal links into r31, R-type writes rd, lw writes rt
    assign waddr = link ? 5'd31 : (reg_dst ? instr[15:11] : instr[20:16]);

    mips_regfile regfile_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (rf_we),
        .raddr1 (instr[25:21]),
        .raddr2 (instr[20:16]),
        .waddr  (waddr),
        .wdata  (rf_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    assign alu_b = alu_src ? imm_ext : rdata2;

    mips_alu alu_i (
        .a      (rdata1),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (zero)
    );

    // ========================================
    // memory strobes and write-back
    // ========================================
    // no stores or register writes while held in reset
    assign cen   = ~((mem_read | mem_write) & rst_n);
    assign wen   = ~(mem_write & rst_n);
    assign rf_we = reg_write & rst_n;

    // byte address from the ALU, dropped to a word index
    assign dmem_addr  = alu_result[`MIPS_DMEM_AW+1:2];
    assign dmem_wdata = rdata2;
    assign imem_addr  = pc;

    assign rf_wdata = link ? pc_plus4 : (mem_to_reg ? dmem_rdata : alu_result);

endmodule

/* verif/tb_mips_mem.sv */
/*
 * Instruction ROM and data SRAM models for the core testbench.
 * The testbench loads both arrays through hierarchical writes before reset.
 */

`include "mips_params.svh"

module tb_mips_mem (
    input  logic                 clk,
    input  mips_pkg::word_t      imem_addr,
    output mips_pkg::word_t      instr,
    input  mips_pkg::dmem_addr_t dmem_addr,
    input  mips_pkg::word_t      dmem_wdata,
    output mips_pkg::word_t      dmem_rdata,
    input  logic                 cen,
    input  logic                 wen
);
    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    word_t rom [256];
    word_t ram [2**`MIPS_DMEM_AW];

    // both read ports are asynchronous
    assign instr      = rom[imem_addr[9:2]];
    assign dmem_rdata = ram[dmem_addr];

    always @(posedge clk) begin
        if (!cen && !wen) begin
            ram[dmem_addr] <= dmem_wdata;
        end
    end

endmodule

/* verif/tb_mips_core.sv */
/*
 * Directed testbench for the single-cycle MIPS core.
 * Each test loads a small program, resets the core and runs it for exactly
 * the number of instructions it executes, then checks the SRAM and write-back trace.
 */

`include "mips_params.svh"

module tb_mips_core;
    timeunit 1ns;
    timeprecision 1ps;

    import mips_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int SAMPLE_DELAY = 5;
    localparam int NUM_TESTS    = 6;
    // executed instructions over all programs
    localparam int RUN_CYCLES   = 12 + 5 + 6 + 3 + 3;
    localparam int CYCLE_LIMIT  = (RUN_CYCLES + NUM_TESTS * RESET_CYCLES) * 2;

    logic                 clk;
    logic                 rst_n;
    word_t                imem_addr, instr, dmem_wdata, dmem_rdata, rf_wdata;
    mips_pkg::dmem_addr_t dmem_addr;
    logic                 cen, wen, rf_we;

    word_t lfsr;
    string cur_test;
    int    checks = 0;
    int    errors = 0;
    int    test_start_errors;
    int    cycle_count = 0;
    // per-cycle trace of the running program
    word_t pc_tr [32];
    logic  we_tr [32];
    word_t wd_tr [32];

    mips_core dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .instr      (instr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .cen        (cen),
        .wen        (wen),
        .rf_we      (rf_we),
        .rf_wdata   (rf_wdata)
    );

    tb_mips_mem mem_i (
        .clk        (clk),
        .imem_addr  (imem_addr),
        .instr      (instr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .cen        (cen),
        .wen        (wen)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================
    // helpers
    // ========================================
    // taps 32, 22, 2, 1
    function automatic word_t next_lfsr(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t rand_word();
        word_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = next_lfsr(lfsr);
            w = {w[30:0], lfsr[31]};
        end
        return w;
    endfunction

    function automatic word_t rtype_word(input funct_t fn, input int rs, input int rt,
                                         input int rd);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic word_t itype_word(input opcode_t op, input int rs, input int rt,
                                         input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t jtype_word(input opcode_t op, input int word_index);
        return {op, 26'(word_index)};
    endfunction

    function automatic word_t fill_word(input int addr);
        return {16'hc0de, 16'(addr)};
    endfunction

    task automatic check_val(input string what, input word_t exp, input word_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic clear_memories();
        for (int i = 0; i < 256; i++) begin
            mem_i.rom[i] = '0;
        end
        for (int i = 0; i < 2**`MIPS_DMEM_AW; i++) begin
            mem_i.ram[i] = fill_word(i);
        end
    endtask

    // called on a falling edge, holds the core in reset while loading
    task automatic begin_test(input string name);
        cur_test = name;
        test_start_errors = errors;
        rst_n = 1'b0;
        clear_memories();
    endtask

    task automatic end_test();
        $display("test %-6s %s", cur_test, (errors == test_start_errors) ? "ok" : "failed");
    endtask

    // reset checks, then one sample per executed instruction
    task automatic reset_and_run(input int n);
        for (int i = 0; i < RESET_CYCLES; i++) begin
            #SAMPLE_DELAY;
            check_val("cen in reset", 32'd1, {31'b0, cen});
            check_val("wen in reset", 32'd1, {31'b0, wen});
            check_val("rf_we in reset", 32'd0, {31'b0, rf_we});
            if (i > 0) begin
                check_val("pc in reset", `MIPS_RESET_PC, imem_addr);
            end
            @(negedge clk);
        end
        rst_n = 1'b1;
        for (int i = 0; i < n; i++) begin
            #SAMPLE_DELAY;
            pc_tr[i] = imem_addr;
            we_tr[i] = rf_we;
            wd_tr[i] = rf_wdata;
            @(negedge clk);
        end
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic test_reset();
        begin_test("reset");
        // stores everywhere, so only the gating keeps the SRAM clean
        for (int i = 0; i < 8; i++) begin
            mem_i.rom[i] = itype_word(OP_SW, 0, 0, 4 * i);
        end
        reset_and_run(0);
        for (int i = 0; i < 8; i++) begin
            check_val($sformatf("ram[%0d]", i), fill_word(i), mem_i.ram[i]);
        end
        end_test();
    endtask

    task automatic test_rtype();
        funct_t fns [5] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};
        word_t  exp [5];
        word_t  a;
        word_t  b;
        begin_test("rtype");
        a = rand_word();
        b = rand_word();
        mem_i.ram[0] = a;
        mem_i.ram[1] = b;
        exp[0] = a + b;
        exp[1] = a - b;
        exp[2] = a & b;
        exp[3] = a | b;
        exp[4] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        mem_i.rom[0] = itype_word(OP_LW, 0, 1, 0);
        mem_i.rom[1] = itype_word(OP_LW, 0, 2, 4);
        for (int i = 0; i < 5; i++) begin
            mem_i.rom[2 + i] = rtype_word(fns[i], 1, 2, 3 + i);
            mem_i.rom[7 + i] = itype_word(OP_SW, 0, 3 + i, 8 + 4 * i);
        end
        reset_and_run(12);
        check_val("lw a", a, wd_tr[0]);
        check_val("lw b", b, wd_tr[1]);
        for (int i = 0; i < 5; i++) begin
            check_val($sformatf("rf_we op%0d", i), 32'd1, {31'b0, we_tr[2 + i]});
            check_val($sformatf("rf_wdata op%0d", i), exp[i], wd_tr[2 + i]);
            check_val($sformatf("stored op%0d", i), exp[i], mem_i.ram[2 + i]);
        end
        end_test();
    endtask

    task automatic test_ldst();
        word_t v;
        begin_test("ldst");
        v = rand_word();
        mem_i.ram[0] = v;
        mem_i.ram[1] = 32'd200;
        mem_i.rom[0] = itype_word(OP_LW, 0, 1, 0);
        mem_i.rom[1] = itype_word(OP_LW, 0, 2, 4);
        mem_i.rom[2] = itype_word(OP_SW, 2, 1, -12);
        mem_i.rom[3] = itype_word(OP_LW, 2, 3, -12);
        mem_i.rom[4] = itype_word(OP_SW, 0, 3, 40);
        reset_and_run(5);
        // byte 188 is word 47
        check_val("ram[47]", v, mem_i.ram[47]);
        check_val("ram[46]", fill_word(46), mem_i.ram[46]);
        check_val("ram[48]", fill_word(48), mem_i.ram[48]);
        check_val("lw back", v, wd_tr[3]);
        check_val("ram[10]", v, mem_i.ram[10]);
        end_test();
    endtask

    task automatic test_beq();
        int    exp_pc [6];
        word_t v;
        begin_test("beq");
        v = rand_word();
        mem_i.ram[0] = v;
        mem_i.ram[1] = ~v;
        mem_i.rom[0] = itype_word(OP_LW, 0, 1, 0);
        mem_i.rom[1] = itype_word(OP_LW, 0, 2, 0);
        mem_i.rom[2] = itype_word(OP_LW, 0, 3, 4);
        mem_i.rom[3] = itype_word(OP_BEQ, 1, 2, 1);
        mem_i.rom[4] = itype_word(OP_SW, 0, 1, 32);
        mem_i.rom[5] = itype_word(OP_BEQ, 1, 3, 1);
        mem_i.rom[6] = itype_word(OP_SW, 0, 3, 36);
        exp_pc = '{0, 4, 8, 12, 0, 0};
        // taken from 12, then falls through
        exp_pc[4] = 12 + 4 + (1 << 2);
        exp_pc[5] = exp_pc[4] + 4;
        reset_and_run(6);
        for (int i = 0; i < 6; i++) begin
            check_val($sformatf("pc cycle %0d", i), word_t'(exp_pc[i]), pc_tr[i]);
        end
        check_val("skipped sw", fill_word(8), mem_i.ram[8]);
        check_val("executed sw", ~v, mem_i.ram[9]);
        end_test();
    endtask

    task automatic test_jump();
        begin_test("jump");
        mem_i.rom[0] = jtype_word(OP_J, 2);
        mem_i.rom[1] = itype_word(OP_SW, 0, 0, 44);
        mem_i.rom[2] = jtype_word(OP_JAL, 4);
        mem_i.rom[3] = itype_word(OP_SW, 0, 0, 48);
        mem_i.rom[4] = itype_word(OP_SW, 0, 31, 52);
        reset_and_run(3);
        check_val("pc after j", 32'd8, pc_tr[1]);
        check_val("pc after jal", 32'd16, pc_tr[2]);
        check_val("jal rf_we", 32'd1, {31'b0, we_tr[1]});
        check_val("jal link", 32'd8 + 32'd4, wd_tr[1]);
        check_val("ram[11]", fill_word(11), mem_i.ram[11]);
        check_val("ram[12]", fill_word(12), mem_i.ram[12]);
        check_val("stored r31", 32'd8 + 32'd4, mem_i.ram[13]);
        end_test();
    endtask

    task automatic test_zero_reg();
        begin_test("r0");
        mem_i.ram[0] = rand_word() | 32'd1;
        mem_i.rom[0] = itype_word(OP_LW, 0, 1, 0);
        mem_i.rom[1] = rtype_word(FN_ADD, 1, 1, 0);
        mem_i.rom[2] = itype_word(OP_SW, 0, 0, 56);
        reset_and_run(3);
        check_val("stored r0", 32'd0, mem_i.ram[14]);
        end_test();
    endtask

    // ========================================
    // sequence and report
    // ========================================
    initial begin
        rst_n = 1'b0;
        lfsr  = 32'hcac7e4e2;
        clear_memories();
        @(negedge clk);
        test_reset();
        test_rtype();
        test_ldst();
        test_beq();
        test_jump();
        test_zero_reg();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

endmodule

/* compile.f */
+incdir+rtl
rtl/mips_pkg.sv
rtl/mips_alu.sv
rtl/mips_decoder.sv
rtl/mips_regfile.sv
rtl/mips_fetch.sv
rtl/mips_core.sv
verif/tb_mips_mem.sv
verif/tb_mips_core.sv

/* Makefile */
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
